// ==== all.f ====
verilog/dcache_pkg.sv
verilog/victim_lfsr.sv
verilog/cache_sram.sv
verilog/tag_array.sv
verilog/data_array.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/tb_dcache.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_dcache -o sim_dcache

# a failing run stops with a nonzero status, so keep going to the search
sim_out=$(./obj_dir/sim_dcache 2>&1) || true
echo "$sim_out"

if grep -qx "Finished with no errors" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

// ==== tb/tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int INDEX_WIDTH = 4;
    localparam int TIMEOUT     = 300;  // cycles per wait
    localparam logic [31:0] RNG_SEED = 32'hdbd5f92b;

    logic  clock = 1'b0;
    logic  reset_n = 1'b0;
    logic  req_valid = 1'b0;
    logic  req_write = 1'b0;
    addr_t req_addr = '0;
    word_t req_wdata = '0;
    word_t req_wmask = '0;
    logic  req_ready, done, mem_valid, mem_write;
    word_t rdata;
    addr_t mem_addr;
    line_t mem_wdata;
    logic  mem_ready = 1'b0;
    logic  mem_done = 1'b0;
    line_t mem_rdata = '0;

    logic [31:0] data_rng = RNG_SEED;
    logic [31:0] mem_rng = ~RNG_SEED;   // stall lengths
    line_t       backing [addr_t];      // lines written back to memory
    line_t       shadow [addr_t];       // lines as the cache should hold them
    int          read_count = 0;
    int          write_count = 0;
    addr_t       last_read_addr = '0;
    addr_t       last_write_addr = '0;

    always #2 clock = ~clock;

    dcache_top #(.INDEX_WIDTH(INDEX_WIDTH)) dut (
        .clock, .reset_n,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_wmask,
        .req_ready, .done, .rdata,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_done, .mem_rdata
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t rand_word();
        logic [31:0] hi;
        data_rng = xorshift(data_rng);
        hi = data_rng;
        data_rng = xorshift(data_rng);
        return {hi, data_rng};
    endfunction

    function automatic addr_t make_addr(input int tag, input int set, input int word);
        return (addr_t'(tag) << (INDEX_WIDTH + OFFSET_WIDTH))
             | (addr_t'(set) << OFFSET_WIDTH) | (addr_t'(word) << 3);
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    endfunction

    // every word of untouched memory tied to its own address
    function automatic line_t fill_pattern(input addr_t line_addr);
        line_t line;
        addr_t word_addr;
        for (int w = 0; w < LINE_WORDS; w++) begin
            word_addr = line_addr | addr_t'(w << 3);
            line[w] = {word_addr ^ 32'h9e3779b9, ~word_addr};
        end
        return line;
    endfunction

    function automatic line_t backing_line(input addr_t line_addr);
        if (backing.exists(line_addr))
            return backing[line_addr];
        return fill_pattern(line_addr);
    endfunction

    function automatic line_t shadow_line(input addr_t line_addr);
        if (shadow.exists(line_addr))
            return shadow[line_addr];
        return backing_line(line_addr);
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        line_t line;
        line = shadow_line(line_of(a));
        return line[a[5:3]];
    endfunction

    function automatic word_t merge(input word_t old, input word_t data, input word_t mask);
        return (data & mask) | (old & ~mask);
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [511:0] actual,
                         input logic [511:0] expected);
        if (actual !== expected)
            stop_with_failure($sformatf("CHECK FAILED %s: got %0h expected %0h",
                                        name, actual, expected));
    endtask

    // memory responder handles one operation at a time
    always begin : mem_responder
        addr_t op_addr;
        logic  op_write;
        line_t op_data;
        int    delay;
        @(negedge clock);
        if (reset_n && mem_valid) begin
            op_addr  = mem_addr;
            op_write = mem_write;
            op_data  = mem_wdata;
            check("mem_addr[5:0]", 512'(mem_addr[5:0]), 512'(0));
            mem_rng = xorshift(mem_rng);
            delay = int'(mem_rng % 4);
            repeat (delay) @(negedge clock);
            check("mem_valid", 512'(mem_valid), 512'(1'b1));  // held through the stall
            check("mem_addr", 512'(mem_addr), 512'(op_addr));
            check("mem_write", 512'(mem_write), 512'(op_write));
            check("mem_wdata", mem_wdata, op_data);
            mem_ready = 1'b1;
            @(negedge clock);
            mem_ready = 1'b0;
            check("mem_valid", 512'(mem_valid), 512'(1'b0));
            mem_rng = xorshift(mem_rng);
            delay = int'(mem_rng % 4);
            repeat (delay) @(negedge clock);
            if (op_write) begin
                check("mem_wdata", op_data, shadow_line(op_addr));
                backing[op_addr] = op_data;
                write_count++;
                last_write_addr = op_addr;
            end else begin
                mem_rdata = backing_line(op_addr);
                read_count++;
                last_read_addr = op_addr;
            end
            mem_done = 1'b1;
            @(negedge clock);
            mem_done = 1'b0;
        end
    end

    // drives one request from falling edge to falling edge
    task automatic access(input logic write, input addr_t addr, input word_t wdata,
                          input word_t wmask, output word_t data, output int cycles);
        int    waited;
        line_t line;
        waited = 0;
        while (!req_ready) begin
            @(negedge clock);
            waited++;
            if (waited > TIMEOUT)
                stop_with_failure("timed out waiting for req_ready");
        end
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        req_wmask = wmask;
        @(negedge clock);
        req_valid = 1'b0;
        cycles = 1;
        while (!done) begin
            @(negedge clock);
            cycles++;
            if (cycles > TIMEOUT)
                stop_with_failure("timed out waiting for done");
        end
        data = rdata;
        if (write) begin
            line = shadow_line(line_of(addr));
            line[addr[5:3]] = merge(line[addr[5:3]], wdata, wmask);
            shadow[line_of(addr)] = line;
        end
        @(negedge clock);
        check("done", 512'(done), 512'(1'b0));  // single-cycle pulse
        check("req_ready", 512'(req_ready), 512'(1'b1));
    endtask

    task automatic store(input addr_t addr, input word_t data, input word_t mask);
        word_t unused;
        int    cycles;
        access(1'b1, addr, data, mask, unused, cycles);
    endtask

    task automatic read_and_compare(input addr_t addr);
        word_t data;
        int    cycles;
        access(1'b0, addr, '0, '0, data, cycles);
        check("rdata", 512'(data), 512'(shadow_word(addr)));
    endtask

    task automatic reset_state_checks();
        check("req_ready", 512'(req_ready), 512'(1'b1));
        check("done", 512'(done), 512'(1'b0));
        check("mem_valid", 512'(mem_valid), 512'(1'b0));
    endtask

    task automatic read_miss_then_hit();
        addr_t a;
        word_t data;
        int    cycles;
        line_t line;
        a = make_addr(5, 3, 2);
        line = fill_pattern(line_of(a));
        access(1'b0, a, '0, '0, data, cycles);
        check("miss reads", 512'(read_count), 512'(1));
        check("miss writes", 512'(write_count), 512'(0));
        check("fetch addr", 512'(last_read_addr), 512'(line_of(a)));
        check("rdata", 512'(data), 512'(line[2]));
        access(1'b0, a + 24, '0, '0, data, cycles);  // word 5, same line
        check("hit reads", 512'(read_count), 512'(1));
        check("hit writes", 512'(write_count), 512'(0));
        check("hit cycles", 512'(cycles), 512'(2));
        check("rdata", 512'(data), 512'(line[5]));
    endtask

    task automatic partial_write_hit();
        addr_t a;
        word_t old, data, mask, got;
        int    cycles;
        a = make_addr(5, 3, 6);
        old = shadow_word(a);
        read_and_compare(a);
        data = rand_word();
        mask = rand_word();
        access(1'b1, a, data, mask, got, cycles);
        check("write hit cycles", 512'(cycles), 512'(2));
        access(1'b0, a, '0, '0, got, cycles);
        check("merged word", 512'(got), 512'((data & mask) | (old & ~mask)));
        check("hit reads", 512'(read_count), 512'(1));
        check("hit writes", 512'(write_count), 512'(0));
    endtask

    task automatic write_miss_merge();
        addr_t a;
        word_t data, mask, got, expected;
        int    cycles;
        line_t line;
        a = make_addr(9, 7, 4);
        line = fill_pattern(line_of(a));
        data = rand_word();
        mask = rand_word();
        store(a, data, mask);
        check("fetch count", 512'(read_count), 512'(2));
        check("fetch addr", 512'(last_read_addr), 512'(line_of(a)));
        check("write-backs", 512'(write_count), 512'(0));
        for (int w = 0; w < LINE_WORDS; w++) begin
            access(1'b0, line_of(a) + addr_t'(w * 8), '0, '0, got, cycles);
            expected = (w == 4) ? ((data & mask) | (line[w] & ~mask)) : line[w];
            check($sformatf("rdata word %0d", w), 512'(got), 512'(expected));
        end
        check("fetch count", 512'(read_count), 512'(2));
    endtask

    task automatic same_set_eviction();
        addr_t lines [9];
        int    writes0;
        for (int i = 0; i < 3; i++) begin
            lines[i]     = make_addr(20 + i, 11, i);
            lines[3 + i] = make_addr(30 + i, 12, i);
            lines[6 + i] = make_addr(40 + i, 13, i);
        end
        // set with one dirty line where either way may be evicted
        store(lines[0], rand_word(), rand_word());
        read_and_compare(lines[1]);
        writes0 = write_count;
        read_and_compare(lines[2]);
        if (write_count - writes0 > 1)
            stop_with_failure("more than one write-back for a single miss");
        if (write_count != writes0)
            check("write-back addr", 512'(last_write_addr), 512'(line_of(lines[0])));
        // clean lines never write back
        writes0 = write_count;
        for (int i = 3; i < 6; i++)
            read_and_compare(lines[i]);
        check("clean evict writes", 512'(write_count - writes0), 512'(0));
        // both ways dirty so exactly one write-back
        store(lines[6], rand_word(), rand_word());
        store(lines[7], rand_word(), rand_word());
        writes0 = write_count;
        read_and_compare(lines[8]);
        check("dirty evict writes", 512'(write_count - writes0), 512'(1));
        if (last_write_addr != line_of(lines[6]) && last_write_addr != line_of(lines[7]))
            stop_with_failure("write-back address belongs to no dirty line of the set");
        for (int i = 0; i < 9; i++)
            read_and_compare(lines[i]);
    endtask

    task automatic random_traffic();
        addr_t a;
        for (int i = 0; i < 120; i++) begin
            data_rng = xorshift(data_rng);
            a = make_addr(int'(16'h100 + data_rng[1:0]), int'(data_rng[9:8] % 3),
                          int'(data_rng[18:16]));
            if (data_rng[24])
                store(a, rand_word(), rand_word());
            else
                read_and_compare(a);
        end
    endtask

    initial begin
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        reset_state_checks();
        read_miss_then_hit();
        partial_write_hit();
        write_miss_merge();
        same_set_eviction();
        random_traffic();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== verilog/cache_sram.sv ====
`timescale 1ns/100ps

module cache_sram #(
    parameter int  DEPTH_BITS = 4,
    parameter type payload_t  = logic [31:0]
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  rd,
    input  logic                  wr,
    input  logic [DEPTH_BITS-1:0] rd_addr,
    input  logic [DEPTH_BITS-1:0] wr_addr,
    input  payload_t              wr_data,
    output payload_t              rd_data
);

    payload_t mem [2**DEPTH_BITS];

    // contents come up zero so valid bits start cleared
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 2**DEPTH_BITS; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr)
                mem[wr_addr] <= wr_data;
            if (rd)
                rd_data <= mem[rd_addr];  // output holds until the next read
        end
    end

endmodule

// ==== verilog/data_array.sv ====
`timescale 1ns/100ps

module data_array
    import dcache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      line_rd,
    input  logic                      line_wr,
    input  logic                      line_from_mem,
    input  logic                      merge_store,
    input  logic [INDEX_WIDTH-1:0]    set_index,
    input  way_t                      sel_way,
    input  logic [WORD_SEL_WIDTH-1:0] word_sel,
    input  word_t                     store_word,
    input  word_t                     store_mask,
    input  line_t                     mem_rdata,
    output line_t                     line_out,
    output word_t                     word_out
);

    line_t rd_line [WAY_COUNT];
    line_t base_line;
    line_t wr_line;
    way_t  held_way;  // way whose line was last read

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            held_way <= 1'b0;
        end else if (line_rd) begin
            held_way <= sel_way;
        end
    end

    for (genvar w = 0; w < WAY_COUNT; w++) begin : g_way
        cache_sram #(
            .DEPTH_BITS (INDEX_WIDTH),
            .payload_t  (line_t)
        ) u_line_sram (
            .clock   (clock),
            .reset_n (reset_n),
            .rd      (line_rd && (sel_way == way_t'(w))),
            .wr      (line_wr && (sel_way == way_t'(w))),
            .rd_addr (set_index),
            .wr_addr (set_index),
            .wr_data (wr_line),
            .rd_data (rd_line[w])
        );
    end

    assign line_out = rd_line[held_way];
    assign word_out = line_out[word_sel];

    // refill takes the bus line, a write hit rewrites the held line
    always_comb begin
        base_line = line_from_mem ? mem_rdata : line_out;
        wr_line   = base_line;
        if (merge_store) begin
            wr_line[word_sel] = (store_word & store_mask)
                              | (base_line[word_sel] & ~store_mask);
        end
    end

endmodule

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  logic                      req_valid,
    input  logic                      req_write,
    input  addr_t                     req_addr,
    input  word_t                     req_wdata,
    input  word_t                     req_wmask,
    output logic                      req_ready,
    output logic                      done,
    output word_t                     rdata,
    output logic                      mem_valid,
    output logic                      mem_write,
    output addr_t                     mem_addr,
    output line_t                     mem_wdata,
    input  logic                      mem_ready,
    input  logic                      mem_done,
    input  line_t                     mem_rdata,
    output logic                      tag_rd,
    output logic                      tag_wr,
    output logic                      tag_dirty,
    output logic [INDEX_WIDTH-1:0]    set_index,
    output logic [ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-1:0] tag_value,
    output way_t                      sel_way,
    input  logic                      hit,
    input  logic                      victim_dirty,
    input  way_t                      hit_way,
    input  way_t                      victim_way,
    input  logic [ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-1:0] victim_tag,
    output logic                      line_rd,
    output logic                      line_wr,
    output logic                      line_from_mem,
    output logic                      merge_store,
    output logic [WORD_SEL_WIDTH-1:0] word_sel,
    output word_t                     store_word,
    output word_t                     store_mask,
    input  line_t                     array_line,  // held line from the line store
    input  word_t                     array_word
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, READ_HIT, WRITE_HIT, WRITEBACK, FETCH, REFILL
    } state_t;

    state_t               state, next_state;
    logic                 req_write_q;
    addr_t                addr_q;
    word_t                wdata_q, wmask_q, fill_word_q;
    way_t                 way_q;
    logic [TAG_WIDTH-1:0] vtag_q;
    logic                 mem_valid_q;
    logic                 accept;

    assign accept = req_valid && (state == IDLE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (req_valid) next_state = LOOKUP;
            LOOKUP: begin
                if (hit)
                    next_state = req_write_q ? WRITE_HIT : READ_HIT;
                else
                    next_state = victim_dirty ? WRITEBACK : FETCH;
            end
            WRITEBACK: if (mem_done) next_state = FETCH;
            FETCH:     if (mem_done) next_state = REFILL;
            default:   next_state = IDLE;  // hit states and refill last one cycle
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state       <= IDLE;
            mem_valid_q <= 1'b0;
            req_write_q <= 1'b0;
            way_q       <= 1'b0;
        end else begin
            state <= next_state;
            if (accept)
                req_write_q <= req_write;
            if (state == LOOKUP)
                way_q <= hit ? hit_way : victim_way;
            // bus request drops after the handshake edge
            if (mem_valid_q && mem_ready)
                mem_valid_q <= 1'b0;
            else if ((state == LOOKUP && !hit) || (state == WRITEBACK && mem_done))
                mem_valid_q <= 1'b1;
        end
    end

    // request payload and miss data
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            wmask_q <= req_wmask;
        end
        if (state == LOOKUP)
            vtag_q <= victim_tag;
        if (state == FETCH && mem_done)
            fill_word_q <= mem_rdata[addr_q[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH]];
    end

    // tag store side
    assign tag_rd    = accept;
    assign set_index = (state == IDLE) ? req_addr[OFFSET_WIDTH +: INDEX_WIDTH]
                                       : addr_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag_value = addr_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign tag_wr    = (state == WRITE_HIT) || (state == FETCH && mem_done);
    assign tag_dirty = req_write_q;  // refill by a store is dirty at once
    assign sel_way   = (state == LOOKUP) ? (hit ? hit_way : victim_way) : way_q;

    // line store side
    assign line_rd       = (state == LOOKUP);
    assign line_wr       = tag_wr;  // refill lands on the fetch completion cycle
    assign line_from_mem = (state == FETCH);
    assign merge_store   = req_write_q;
    assign word_sel      = addr_q[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
    assign store_word    = wdata_q;
    assign store_mask    = wmask_q;

    // load/store port
    assign req_ready = (state == IDLE);
    assign done      = (state == READ_HIT) || (state == WRITE_HIT) || (state == REFILL);
    assign rdata     = (state == REFILL) ? fill_word_q : array_word;

    // memory bus
    assign mem_valid = mem_valid_q;
    assign mem_write = (state == WRITEBACK);
    assign mem_addr  = (state == WRITEBACK)
                     ? {vtag_q, addr_q[OFFSET_WIDTH +: INDEX_WIDTH], {OFFSET_WIDTH{1'b0}}}
                     : {addr_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
    assign mem_wdata = array_line;  // victim line stays held through write-back

endmodule

// ==== verilog/dcache_pkg.sv ====
package dcache_pkg;

    // request and line geometry
    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 64;
    localparam int OFFSET_WIDTH   = 6;   // byte offset in a 64-byte line
    localparam int WORD_SEL_WIDTH = 3;   // address bits 5 to 3
    localparam int LINE_WORDS     = 8;
    localparam int WAY_COUNT      = 2;

    // replacement LFSR starts from all ones
    localparam logic [7:0] LFSR_SEED = 8'hff;

    // one data word, also used for the store bit mask
    typedef logic [WORD_WIDTH-1:0] word_t;

    // word 0 sits at the low end of the line
    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef logic way_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== verilog/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4  // 16 sets
) (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  req_valid,
    input  logic  req_write,
    input  addr_t req_addr,
    input  word_t req_wdata,
    input  word_t req_wmask,
    output logic  req_ready,
    output logic  done,
    output word_t rdata,
    output logic  mem_valid,
    output logic  mem_write,
    output addr_t mem_addr,
    output line_t mem_wdata,
    input  logic  mem_ready,
    input  logic  mem_done,
    input  line_t mem_rdata
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    logic                      tag_rd, tag_wr, tag_dirty;
    logic [INDEX_WIDTH-1:0]    set_index;
    logic [TAG_WIDTH-1:0]      tag_value, victim_tag;
    way_t                      sel_way, hit_way, victim_way;
    logic                      hit, victim_dirty;
    logic                      line_rd, line_wr, line_from_mem, merge_store;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    word_t                     store_word, store_mask, word_out;
    line_t                     line_out;
    logic                      random_bit;

    dcache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) u_ctrl (
        .clock, .reset_n,
        .req_valid, .req_write, .req_addr, .req_wdata, .req_wmask,
        .req_ready, .done, .rdata,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_done, .mem_rdata,
        .tag_rd, .tag_wr, .tag_dirty, .set_index, .tag_value, .sel_way,
        .hit, .victim_dirty, .hit_way, .victim_way, .victim_tag,
        .line_rd, .line_wr, .line_from_mem, .merge_store,
        .word_sel, .store_word, .store_mask,
        .array_line (line_out),
        .array_word (word_out)
    );

    victim_lfsr u_lfsr (
        .clock, .reset_n, .random_bit
    );

    tag_array #(.INDEX_WIDTH(INDEX_WIDTH)) u_tags (
        .clock, .reset_n, .tag_rd, .tag_wr, .tag_dirty, .random_bit,
        .set_index, .tag_value, .sel_way,
        .hit, .victim_dirty, .hit_way, .victim_way, .victim_tag
    );

    data_array #(.INDEX_WIDTH(INDEX_WIDTH)) u_lines (
        .clock, .reset_n, .line_rd, .line_wr, .line_from_mem, .merge_store,
        .set_index, .sel_way, .word_sel, .store_word, .store_mask,
        .mem_rdata, .line_out, .word_out
    );

endmodule

// ==== verilog/tag_array.sv ====
`timescale 1ns/100ps

module tag_array
    import dcache_pkg::*;
#(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                                       clock,
    input  logic                                       reset_n,
    input  logic                                       tag_rd,
    input  logic                                       tag_wr,
    input  logic                                       tag_dirty,
    input  logic                                       random_bit,
    input  logic [INDEX_WIDTH-1:0]                     set_index,
    input  logic [ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-1:0] tag_value,
    input  way_t                                       sel_way,
    output logic                                       hit,
    output logic                                       victim_dirty,
    output way_t                                       hit_way,
    output way_t                                       victim_way,
    output logic [ADDR_WIDTH-INDEX_WIDTH-OFFSET_WIDTH-1:0] victim_tag
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    tag_entry_t             rd_entry [WAY_COUNT];
    tag_entry_t             wr_entry;
    logic [WAY_COUNT-1:0]   hit_vec;

    // any write installs a valid entry
    assign wr_entry = '{valid: 1'b1, dirty: tag_dirty, tag: tag_value};

    for (genvar w = 0; w < WAY_COUNT; w++) begin : g_way
        cache_sram #(
            .DEPTH_BITS (INDEX_WIDTH),
            .payload_t  (tag_entry_t)
        ) u_tag_sram (
            .clock   (clock),
            .reset_n (reset_n),
            .rd      (tag_rd),
            .wr      (tag_wr && (sel_way == way_t'(w))),
            .rd_addr (set_index),
            .wr_addr (set_index),
            .wr_data (wr_entry),
            .rd_data (rd_entry[w])
        );

        assign hit_vec[w] = rd_entry[w].valid && (rd_entry[w].tag == tag_value);
    end

    assign hit     = |hit_vec;
    assign hit_way = hit_vec[1];  // two ways, so way 1 or else way 0

    // fill an empty way first, random choice once the set is full
    always_comb begin
        if (!rd_entry[0].valid)
            victim_way = 1'b0;
        else if (!rd_entry[1].valid)
            victim_way = 1'b1;
        else
            victim_way = random_bit;
    end

    assign victim_dirty = rd_entry[victim_way].valid && rd_entry[victim_way].dirty;
    assign victim_tag   = rd_entry[victim_way].tag;

endmodule

// ==== verilog/victim_lfsr.sv ====
`timescale 1ns/100ps

module victim_lfsr
    import dcache_pkg::*;
(
    input  logic clock,
    input  logic reset_n,
    output logic random_bit
);

    logic [7:0] lfsr;
    logic       feedback;

    // taps for x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign feedback = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], feedback};  // free running
        end
    end

    assign random_bit = lfsr[0];

endmodule
